/* src/ccip_shim_pkg.sv */
// CCI-P shim shared types
`default_nettype none

package ccip_shim_pkg;

    // Widths that carry a meaning on the MMIO channel
    typedef logic [15:0] t_mmio_addr;
    typedef logic [63:0] t_mmio_data;
    typedef logic [8:0]  t_mmio_tid;

    // Zero is full power, anything else asks the AFU to throttle
    typedef logic [1:0]  t_power_state;

    // Count, step and limit of the engine
    typedef logic [31:0] t_count;

    // FIU to AFU, one MMIO beat per cycle at most
    typedef struct packed {
        logic       mmio_wr_valid;
        logic       mmio_rd_valid;
        t_mmio_addr addr;
        t_mmio_data data;
        t_mmio_tid  tid;
    } t_ccip_rx;

    // AFU to FIU, read response tagged with the request tid
    typedef struct packed {
        logic       mmio_rsp_valid;
        t_mmio_tid  tid;
        t_mmio_data data;
    } t_ccip_tx;

    // CSR block to engine
    typedef struct packed {
        logic   enable;
        logic   clear;
        t_count step;
        t_count limit;
        logic   pause;
        logic   halt;
    } t_engine_ctrl;

    // Engine back to CSR block
    typedef struct packed {
        t_count count;
        logic   done;
    } t_engine_status;

    // CSR map, 8-byte aligned
    localparam t_mmio_addr CSR_ID      = 16'h0000;
    localparam t_mmio_addr CSR_SCRATCH = 16'h0008;
    localparam t_mmio_addr CSR_CONTROL = 16'h0010;
    localparam t_mmio_addr CSR_STEP    = 16'h0018;
    localparam t_mmio_addr CSR_LIMIT   = 16'h0020;
    localparam t_mmio_addr CSR_STATUS  = 16'h0028;
    localparam t_mmio_addr CSR_COUNT   = 16'h0030;

    // Identifies this AFU to host software
    localparam t_mmio_data AFU_ID = 64'h5a3c_9e17_b2d4_0f61;

endpackage

`default_nettype wire

/* src/ccip_reg_stage.sv */
// CCI-P register stages
`default_nettype none

module ccip_reg_stage
#(
    parameter int unsigned N_REG_STAGES   = 2,
    parameter bit          REGISTER_RX    = 1'b1,
    parameter bit          REGISTER_TX    = 1'b1,
    parameter bit          REGISTER_RESET = 1'b1,
    parameter bit          REGISTER_ERROR = 1'b1
)
(
    input  logic                        clk,
    input  logic                        rst_n,

    // Platform side
    input  ccip_shim_pkg::t_ccip_rx     fiu_rx,
    output ccip_shim_pkg::t_ccip_tx     fiu_tx,
    input  ccip_shim_pkg::t_power_state fiu_pwr_state,
    input  logic                        fiu_error,

    // AFU side
    output logic                        afu_rst_n,
    output ccip_shim_pkg::t_ccip_rx     afu_rx,
    input  ccip_shim_pkg::t_ccip_tx     afu_tx,
    output ccip_shim_pkg::t_power_state afu_pwr_state,
    output logic                        afu_error
);

    import ccip_shim_pkg::*;

    // Reset chain
    if (REGISTER_RESET && N_REG_STAGES > 0)
    begin : reg_reset
        logic [N_REG_STAGES-1:0] rst_q;

        // Assert at once, release one stage per cycle
        always_ff @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                rst_q <= '0;
            end
            else
            begin
                rst_q[0] <= 1'b1;
                for (int i = 1; i < N_REG_STAGES; i++)
                    rst_q[i] <= rst_q[i-1];
            end
        end

        assign afu_rst_n = rst_q[N_REG_STAGES-1];
    end
    else
    begin : wire_reset
        assign afu_rst_n = rst_n;
    end

    // Receive path
    if (REGISTER_RX && N_REG_STAGES > 0)
    begin : reg_rx
        t_ccip_rx                rx_q [N_REG_STAGES];
        logic [N_REG_STAGES-1:0] wr_vld_q;
        logic [N_REG_STAGES-1:0] rd_vld_q;

        // Payload shifts freely
        always_ff @(posedge clk)
        begin
            rx_q[0] <= fiu_rx;
            for (int i = 1; i < N_REG_STAGES; i++)
                rx_q[i] <= rx_q[i-1];
        end

        // Valid flags cleared on reset so no stale beat leaks out
        always_ff @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                wr_vld_q <= '0;
                rd_vld_q <= '0;
            end
            else
            begin
                wr_vld_q[0] <= fiu_rx.mmio_wr_valid;
                rd_vld_q[0] <= fiu_rx.mmio_rd_valid;
                for (int i = 1; i < N_REG_STAGES; i++)
                begin
                    wr_vld_q[i] <= wr_vld_q[i-1];
                    rd_vld_q[i] <= rd_vld_q[i-1];
                end
            end
        end

        always_comb
        begin
            afu_rx               = rx_q[N_REG_STAGES-1];
            afu_rx.mmio_wr_valid = wr_vld_q[N_REG_STAGES-1];
            afu_rx.mmio_rd_valid = rd_vld_q[N_REG_STAGES-1];
        end
    end
    else
    begin : wire_rx
        assign afu_rx = fiu_rx;
    end

    // Transmit path
    if (REGISTER_TX && N_REG_STAGES > 0)
    begin : reg_tx
        t_ccip_tx                tx_q [N_REG_STAGES];
        logic [N_REG_STAGES-1:0] rsp_vld_q;

        always_ff @(posedge clk)
        begin
            tx_q[0] <= afu_tx;
            for (int i = 1; i < N_REG_STAGES; i++)
                tx_q[i] <= tx_q[i-1];
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                rsp_vld_q <= '0;
            end
            else
            begin
                rsp_vld_q[0] <= afu_tx.mmio_rsp_valid;
                for (int i = 1; i < N_REG_STAGES; i++)
                    rsp_vld_q[i] <= rsp_vld_q[i-1];
            end
        end

        always_comb
        begin
            fiu_tx                = tx_q[N_REG_STAGES-1];
            fiu_tx.mmio_rsp_valid = rsp_vld_q[N_REG_STAGES-1];
        end
    end
    else
    begin : wire_tx
        assign fiu_tx = afu_tx;
    end

    // Power state and error
    if (REGISTER_ERROR && N_REG_STAGES > 0)
    begin : reg_err
        t_power_state            pwr_q [N_REG_STAGES];
        logic [N_REG_STAGES-1:0] err_q;

        // Both steer the engine, so they come out of reset quiet
        always_ff @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                for (int i = 0; i < N_REG_STAGES; i++)
                    pwr_q[i] <= '0;
                err_q <= '0;
            end
            else
            begin
                pwr_q[0] <= fiu_pwr_state;
                err_q[0] <= fiu_error;
                for (int i = 1; i < N_REG_STAGES; i++)
                begin
                    pwr_q[i] <= pwr_q[i-1];
                    err_q[i] <= err_q[i-1];
                end
            end
        end

        assign afu_pwr_state = pwr_q[N_REG_STAGES-1];
        assign afu_error     = err_q[N_REG_STAGES-1];
    end
    else
    begin : wire_err
        assign afu_pwr_state = fiu_pwr_state;
        assign afu_error     = fiu_error;
    end

endmodule

`default_nettype wire

/* src/afu_csr_block.sv */
// AFU control and status registers
`default_nettype none

module afu_csr_block
(
    input  logic                          clk,
    input  logic                          rst_n,

    // MMIO channel
    input  ccip_shim_pkg::t_ccip_rx       rx,
    output ccip_shim_pkg::t_ccip_tx       tx,

    // Platform state, already staged
    input  ccip_shim_pkg::t_power_state   pwr_state,
    input  logic                          error,

    // Engine
    output ccip_shim_pkg::t_engine_ctrl   engine_ctrl,
    input  ccip_shim_pkg::t_engine_status engine_status
);

    import ccip_shim_pkg::*;

    t_mmio_data scratch_q;
    t_count     step_q;
    t_count     limit_q;
    logic       enable_q;
    logic       clear_q;
    logic       err_q;

    t_mmio_data rd_data;
    logic       rsp_vld_q;
    t_mmio_tid  rsp_tid_q;
    t_mmio_data rsp_data_q;

    // Write decode, registers change on the edge after the beat
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scratch_q <= '0;
            step_q    <= '0;
            limit_q   <= '0;
            enable_q  <= 1'b0;
            clear_q   <= 1'b0;
            err_q     <= 1'b0;
        end
        else
        begin
            // Clear only lives for one cycle
            clear_q <= 1'b0;

            if (rx.mmio_wr_valid)
            begin
                case (rx.addr)
                    CSR_SCRATCH: scratch_q <= rx.data;
                    CSR_STEP:    step_q    <= rx.data[$bits(t_count)-1:0];
                    CSR_LIMIT:   limit_q   <= rx.data[$bits(t_count)-1:0];
                    CSR_CONTROL:
                    begin
                        enable_q <= rx.data[0];
                        clear_q  <= rx.data[1];
                    end
                    // Write one to bit 1 acknowledges the error
                    CSR_STATUS:
                    begin
                        if (rx.data[1])
                            err_q <= 1'b0;
                    end
                    default: ;
                endcase
            end

            // A new error wins over an acknowledge in the same cycle
            if (error)
                err_q <= 1'b1;
        end
    end

    // Read mux
    always_comb
    begin
        rd_data = '0;
        case (rx.addr)
            CSR_ID:      rd_data = AFU_ID;
            CSR_SCRATCH: rd_data = scratch_q;
            CSR_CONTROL: rd_data = {63'b0, enable_q};
            CSR_STEP:    rd_data = {32'b0, step_q};
            CSR_LIMIT:   rd_data = {32'b0, limit_q};
            CSR_STATUS:  rd_data = {60'b0, pwr_state, err_q, engine_status.done};
            CSR_COUNT:   rd_data = {32'b0, engine_status.count};
            default:     rd_data = '0;
        endcase
    end

    // Response valid, one per read request
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rsp_vld_q <= 1'b0;
        else
            rsp_vld_q <= rx.mmio_rd_valid;
    end

    // Response payload, tid echoed back
    always_ff @(posedge clk)
    begin
        if (rx.mmio_rd_valid)
        begin
            rsp_tid_q  <= rx.tid;
            rsp_data_q <= rd_data;
        end
    end

    always_comb
    begin
        tx.mmio_rsp_valid = rsp_vld_q;
        tx.tid            = rsp_tid_q;
        tx.data           = rsp_data_q;
    end

    // Engine steering
    always_comb
    begin
        engine_ctrl.enable = enable_q;
        engine_ctrl.clear  = clear_q;
        engine_ctrl.step   = step_q;
        engine_ctrl.limit  = limit_q;
        // Throttle whenever the platform leaves full power
        engine_ctrl.pause  = (pwr_state != '0);
        engine_ctrl.halt   = err_q;
    end

endmodule

`default_nettype wire

/* src/afu_counter_engine.sv */
// Saturating step counter
`default_nettype none

module afu_counter_engine
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  ccip_shim_pkg::t_engine_ctrl   ctrl,
    output ccip_shim_pkg::t_engine_status status
);

    import ccip_shim_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } t_state;

    t_state              state_q;
    t_state              state_d;
    t_count              count_q;
    t_count              count_d;
    logic [$bits(t_count):0] sum;
    t_count              sum_sat;

    // One extra bit catches wrap before the limit compare
    assign sum     = {1'b0, count_q} + {1'b0, ctrl.step};
    assign sum_sat = (sum >= {1'b0, ctrl.limit}) ? ctrl.limit : sum[$bits(t_count)-1:0];

    always_comb
    begin
        state_d = state_q;
        count_d = count_q;
        if (ctrl.clear)
        begin
            state_d = ST_IDLE;
            count_d = '0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (ctrl.enable)
                        state_d = ST_RUN;
                end
                ST_RUN:
                begin
                    if (!ctrl.enable)
                    begin
                        state_d = ST_IDLE;
                    end
                    // Pause and halt hold the count where it is
                    else if (!ctrl.pause && !ctrl.halt)
                    begin
                        count_d = sum_sat;
                        if (sum_sat == ctrl.limit && ctrl.limit != '0)
                            state_d = ST_DONE;
                    end
                end
                ST_DONE:
                begin
                    // Limit moved, run again
                    if (count_q != ctrl.limit)
                        state_d = ctrl.enable ? ST_RUN : ST_IDLE;
                end
                default: state_d = ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= ST_IDLE;
            count_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            count_q <= count_d;
        end
    end

    assign status.count = count_q;
    assign status.done  = (count_q == ctrl.limit) && (ctrl.limit != '0);

endmodule

`default_nettype wire

/* src/ccip_afu_top.sv */
// CCI-P counting AFU top
`default_nettype none

module ccip_afu_top
#(
    parameter int unsigned N_REG_STAGES   = 2,
    parameter bit          REGISTER_RX    = 1'b1,
    parameter bit          REGISTER_TX    = 1'b1,
    parameter bit          REGISTER_RESET = 1'b1,
    parameter bit          REGISTER_ERROR = 1'b1
)
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  ccip_shim_pkg::t_ccip_rx     fiu_rx,
    output ccip_shim_pkg::t_ccip_tx     fiu_tx,
    input  ccip_shim_pkg::t_power_state fiu_pwr_state,
    input  logic                        fiu_error
);

    import ccip_shim_pkg::*;

    // AFU side of the stage
    logic           afu_rst_n;
    t_ccip_rx       afu_rx;
    t_ccip_tx       afu_tx;
    t_power_state   afu_pwr_state;
    logic           afu_error;

    // CSR to engine
    t_engine_ctrl   engine_ctrl;
    t_engine_status engine_status;

    ccip_reg_stage #(
        .N_REG_STAGES   (N_REG_STAGES),
        .REGISTER_RX    (REGISTER_RX),
        .REGISTER_TX    (REGISTER_TX),
        .REGISTER_RESET (REGISTER_RESET),
        .REGISTER_ERROR (REGISTER_ERROR)
    ) u_reg_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .fiu_rx        (fiu_rx),
        .fiu_tx        (fiu_tx),
        .fiu_pwr_state (fiu_pwr_state),
        .fiu_error     (fiu_error),
        .afu_rst_n     (afu_rst_n),
        .afu_rx        (afu_rx),
        .afu_tx        (afu_tx),
        .afu_pwr_state (afu_pwr_state),
        .afu_error     (afu_error)
    );

    // Both AFU modules run on the staged reset
    afu_csr_block u_csr (
        .clk           (clk),
        .rst_n         (afu_rst_n),
        .rx            (afu_rx),
        .tx            (afu_tx),
        .pwr_state     (afu_pwr_state),
        .error         (afu_error),
        .engine_ctrl   (engine_ctrl),
        .engine_status (engine_status)
    );

    afu_counter_engine u_engine (
        .clk    (clk),
        .rst_n  (afu_rst_n),
        .ctrl   (engine_ctrl),
        .status (engine_status)
    );

endmodule

`default_nettype wire

/* verification/tb_ccip_checker.sv */
// MMIO response checker
`default_nettype none

module tb_ccip_checker
#(
    parameter int RSP_LATENCY = 5
)
(
    input  logic                      clk,
    input  ccip_shim_pkg::t_ccip_tx   fiu_tx,

    // One expectation per read, presented with the request beat
    input  logic                      exp_valid,
    input  ccip_shim_pkg::t_mmio_tid  exp_tid,
    input  ccip_shim_pkg::t_mmio_data exp_data,
    input  ccip_shim_pkg::t_mmio_data exp_mask,
    input  logic                      exp_capture,
    input  logic                      exp_same,

    // Test boundary from the driver
    input  logic                      test_end,
    input  int                        test_id,

    output int                        pending,
    output int                        check_count,
    output int                        error_count
);

    import ccip_shim_pkg::*;

    typedef struct packed {
        t_mmio_tid  tid;
        t_mmio_data data;
        t_mmio_data mask;
        logic       capture;
        logic       same;
        int         due;
    } t_expect;

    // Outstanding reads, oldest first
    t_expect    exp_q [$];
    t_mmio_data captured;
    int         cycle;
    int         test_checks;
    int         test_errors;

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic compare_response(input t_expect e);
        t_mmio_data want;
        check_count++;
        test_checks++;
        // Fixed pipeline, so the arrival cycle is known exactly
        if (cycle != e.due)
        begin
            $display("Response for tid 0x%h arrived at cycle %0d instead of cycle %0d",
                     e.tid, cycle, e.due);
            count_error();
        end
        if (fiu_tx.tid != e.tid)
        begin
            $display("MISMATCH fiu_tx.tid: expected 0x%h, got 0x%h", e.tid, fiu_tx.tid);
            count_error();
        end
        // Frozen counter, the later read must match the earlier one
        if (e.capture)
        begin
            captured = fiu_tx.data;
        end
        else
        begin
            want = e.same ? captured : e.data;
            if (((fiu_tx.data ^ want) & e.mask) != '0)
            begin
                $display("MISMATCH fiu_tx.data: expected 0x%h, got 0x%h (tid 0x%h)",
                         want, fiu_tx.data, e.tid);
                count_error();
            end
        end
    endtask

    // Sample on the rising edge, outputs settle after it
    always @(posedge clk)
    begin
        t_expect head;
        t_expect item;
        cycle = cycle + 1;
        if (fiu_tx.mmio_rsp_valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Unexpected response with tid 0x%h at cycle %0d, no read outstanding",
                         fiu_tx.tid, cycle);
                count_error();
            end
            else
            begin
                head = exp_q.pop_front();
                compare_response(head);
            end
        end
        else if (exp_q.size() != 0 && exp_q[0].due < cycle)
        begin
            head = exp_q.pop_front();
            $display("No response for the read with tid 0x%h, due at cycle %0d",
                     head.tid, head.due);
            count_error();
        end

        if (exp_valid)
        begin
            item.tid     = exp_tid;
            item.data    = exp_data;
            item.mask    = exp_mask;
            item.capture = exp_capture;
            item.same    = exp_same;
            item.due     = cycle + RSP_LATENCY;
            exp_q.push_back(item);
        end

        if (test_end)
        begin
            $display("Test %0d finished: %0d checks, %0d errors",
                     test_id, test_checks, test_errors);
            test_checks = 0;
            test_errors = 0;
        end

        pending = exp_q.size();
    end

endmodule

`default_nettype wire

/* verification/tb_ccip_afu.sv */
// CCI-P AFU testbench
`default_nettype none

module tb_ccip_afu;

    import ccip_shim_pkg::*;

    localparam int          N_STAGES   = 2;
    localparam int          MAX_POLLS  = 30;
    localparam int          RSP_WAIT   = 20;
    localparam int          DRAIN_WAIT = 50;
    localparam logic [31:0] SEED       = 32'hb2e3_4a8c;

    // Row operations, reads split by how the value is judged
    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_READ_CAPTURE,
        OP_READ_SAME,
        OP_POWER,
        OP_ERROR,
        OP_WAIT_DONE,
        OP_IDLE
    } t_op;

    typedef struct packed {
        t_op        op;
        t_mmio_addr addr;
        t_mmio_data data;
        t_mmio_data expected;
        int         test;
    } t_row;

    logic         clk;
    logic         rst_n;
    t_ccip_rx     fiu_rx;
    t_ccip_tx     fiu_tx;
    t_power_state fiu_pwr_state;
    logic         fiu_error;

    // Driver to checker
    logic         exp_valid;
    t_mmio_tid    exp_tid;
    t_mmio_data   exp_data;
    t_mmio_data   exp_mask;
    logic         exp_capture;
    logic         exp_same;
    logic         test_end;
    int           test_id;
    int           pending;
    int           check_count;
    int           error_count;

    t_row         rows [$];
    t_mmio_tid    tid_next;
    int           drv_errors;
    int           tests_run;
    int           cycles;
    int           timeout_limit;

    ccip_afu_top #(
        .N_REG_STAGES (N_STAGES)
    ) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .fiu_rx        (fiu_rx),
        .fiu_tx        (fiu_tx),
        .fiu_pwr_state (fiu_pwr_state),
        .fiu_error     (fiu_error)
    );

    // Request to response through both stage chains and the CSR flop
    tb_ccip_checker #(
        .RSP_LATENCY (2 * N_STAGES + 1)
    ) u_checker (
        .clk         (clk),
        .fiu_tx      (fiu_tx),
        .exp_valid   (exp_valid),
        .exp_tid     (exp_tid),
        .exp_data    (exp_data),
        .exp_mask    (exp_mask),
        .exp_capture (exp_capture),
        .exp_same    (exp_same),
        .test_end    (test_end),
        .test_id     (test_id),
        .pending     (pending),
        .check_count (check_count),
        .error_count (error_count)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (timeout_limit > 0 && cycles > timeout_limit)
        begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic void add_row(input t_op op, input t_mmio_addr addr,
                                    input t_mmio_data data, input t_mmio_data expected,
                                    input int test);
        t_row r;
        r.op       = op;
        r.addr     = addr;
        r.data     = data;
        r.expected = expected;
        r.test     = test;
        rows.push_back(r);
    endfunction

    // STATUS layout: power state in 3:2, sticky error in 1, done in 0
    function automatic void build_table();
        t_mmio_data r1;
        t_mmio_data r2;
        r1 = {$urandom(), $urandom()};
        r2 = {$urandom(), $urandom()};

        // Reset values, no response before the first read
        add_row(OP_IDLE,  '0,          64'd4, '0,     1);
        add_row(OP_READ,  CSR_ID,      '0,    AFU_ID, 1);
        add_row(OP_READ,  CSR_SCRATCH, '0,    '0,     1);
        add_row(OP_READ,  CSR_CONTROL, '0,    '0,     1);
        add_row(OP_READ,  CSR_STEP,    '0,    '0,     1);
        add_row(OP_READ,  CSR_LIMIT,   '0,    '0,     1);
        add_row(OP_READ,  CSR_STATUS,  '0,    '0,     1);
        add_row(OP_READ,  CSR_COUNT,   '0,    '0,     1);

        // Scratch readback, then a burst of reads with distinct tids
        add_row(OP_WRITE, CSR_SCRATCH, r1, '0,     2);
        add_row(OP_READ,  CSR_SCRATCH, '0, r1,     2);
        add_row(OP_WRITE, CSR_SCRATCH, r2, '0,     2);
        add_row(OP_READ,  CSR_SCRATCH, '0, r2,     2);
        add_row(OP_READ,  CSR_ID,      '0, AFU_ID, 2);
        add_row(OP_READ,  16'h0038,    '0, '0,     2);
        add_row(OP_READ,  16'h0104,    '0, '0,     2);
        add_row(OP_READ,  16'hfff8,    '0, '0,     2);
        add_row(OP_READ,  CSR_SCRATCH, '0, r2,     2);

        // 100 is not a multiple of 7, so the last step saturates
        add_row(OP_WRITE,     CSR_STEP,    64'd7,   '0,     3);
        add_row(OP_WRITE,     CSR_LIMIT,   64'd100, '0,     3);
        add_row(OP_READ,      CSR_STEP,    '0,      64'd7,  3);
        add_row(OP_READ,      CSR_LIMIT,   '0,      64'd100, 3);
        add_row(OP_WRITE,     CSR_CONTROL, 64'd1,   '0,     3);
        add_row(OP_READ,      CSR_CONTROL, '0,      64'd1,  3);
        add_row(OP_WAIT_DONE, CSR_STATUS,  '0,      '0,     3);
        add_row(OP_READ,      CSR_COUNT,   '0,      64'd100, 3);
        // Done only
        add_row(OP_READ,      CSR_STATUS,  '0,      64'h1,  3);
        // Clear with enable dropped so the count stays at zero
        add_row(OP_WRITE,     CSR_CONTROL, 64'd2,   '0,     3);
        add_row(OP_IDLE,      '0,          64'd2,   '0,     3);
        add_row(OP_READ,      CSR_COUNT,   '0,      '0,     3);
        add_row(OP_READ,      CSR_STATUS,  '0,      '0,     3);
        add_row(OP_READ,      CSR_CONTROL, '0,      '0,     3);

        // Throttle mid run
        add_row(OP_WRITE,        CSR_STEP,    64'd5,   '0, 4);
        add_row(OP_WRITE,        CSR_LIMIT,   64'd203, '0, 4);
        add_row(OP_WRITE,        CSR_CONTROL, 64'd1,   '0, 4);
        add_row(OP_IDLE,         '0,          64'd10,  '0, 4);
        add_row(OP_POWER,        '0,          64'd2,   '0, 4);
        add_row(OP_READ_CAPTURE, CSR_COUNT,   '0,      '0, 4);
        add_row(OP_IDLE,         '0,          64'd3,   '0, 4);
        add_row(OP_READ_SAME,    CSR_COUNT,   '0,      '0, 4);
        // Power state 2 in bits 3:2, not done yet
        add_row(OP_READ,         CSR_STATUS,  '0,      64'h8,  4);
        add_row(OP_POWER,        '0,          64'd0,   '0, 4);
        add_row(OP_WAIT_DONE,    CSR_STATUS,  '0,      '0, 4);
        add_row(OP_READ,         CSR_COUNT,   '0,      64'd203, 4);

        // Platform error halts the run until acknowledged
        add_row(OP_WRITE,        CSR_CONTROL, 64'd2,  '0, 5);
        add_row(OP_IDLE,         '0,          64'd2,  '0, 5);
        add_row(OP_READ,         CSR_COUNT,   '0,     '0, 5);
        add_row(OP_WRITE,        CSR_CONTROL, 64'd1,  '0, 5);
        add_row(OP_IDLE,         '0,          64'd10, '0, 5);
        add_row(OP_ERROR,        '0,          '0,     '0, 5);
        add_row(OP_READ_CAPTURE, CSR_COUNT,   '0,     '0, 5);
        add_row(OP_IDLE,         '0,          64'd3,  '0, 5);
        add_row(OP_READ_SAME,    CSR_COUNT,   '0,     '0, 5);
        // Sticky error only
        add_row(OP_READ,         CSR_STATUS,  '0,     64'h2,  5);
        add_row(OP_WRITE,        CSR_STATUS,  64'd2,  '0, 5);
        add_row(OP_WAIT_DONE,    CSR_STATUS,  '0,     '0, 5);
        add_row(OP_READ,         CSR_COUNT,   '0,     64'd203, 5);
        add_row(OP_READ,         CSR_STATUS,  '0,     64'h1,  5);
    endfunction

    // Idle beat, power state is held by its own rows
    function automatic void clear_inputs();
        fiu_rx      = '0;
        fiu_error   = 1'b0;
        exp_valid   = 1'b0;
        exp_tid     = '0;
        exp_data    = '0;
        exp_mask    = '0;
        exp_capture = 1'b0;
        exp_same    = 1'b0;
        test_end    = 1'b0;
    endfunction

    // Read beat plus its expectation in the same cycle
    task automatic issue_read(input t_mmio_addr addr, input t_mmio_data expected,
                              input t_mmio_data mask, input logic capture, input logic same);
        fiu_rx.mmio_rd_valid = 1'b1;
        fiu_rx.addr          = addr;
        fiu_rx.tid           = tid_next;
        exp_valid            = 1'b1;
        exp_tid              = tid_next;
        exp_data             = expected;
        exp_mask             = mask;
        exp_capture          = capture;
        exp_same             = same;
        tid_next             = tid_next + 9'd1;
    endtask

    task automatic settle(input int n);
        repeat (n)
        begin
            @(negedge clk);
            clear_inputs();
        end
    endtask

    // Poll STATUS until done, value not judged by the checker
    task automatic wait_done(input int test);
        t_mmio_tid tid;
        int        polls;
        int        waited;
        logic      seen_done;
        polls     = 0;
        seen_done = 1'b0;
        while (!seen_done && polls < MAX_POLLS)
        begin
            if (polls > 0)
            begin
                @(negedge clk);
                clear_inputs();
            end
            tid = tid_next;
            issue_read(CSR_STATUS, '0, '0, 1'b0, 1'b0);
            waited = 0;
            do
            begin
                @(negedge clk);
                clear_inputs();
                waited++;
            end
            while (!(fiu_tx.mmio_rsp_valid && fiu_tx.tid == tid) && waited < RSP_WAIT);
            if (fiu_tx.mmio_rsp_valid && fiu_tx.tid == tid)
                seen_done = fiu_tx.data[0];
            polls++;
        end
        if (!seen_done)
        begin
            $display("Test %0d: engine never reported done in %0d status polls", test, polls);
            drv_errors++;
        end
    endtask

    task automatic apply_row(input t_row r);
        @(negedge clk);
        clear_inputs();
        case (r.op)
            OP_WRITE:
            begin
                fiu_rx.mmio_wr_valid = 1'b1;
                fiu_rx.addr          = r.addr;
                fiu_rx.data          = r.data;
            end
            OP_READ:         issue_read(r.addr, r.expected, '1, 1'b0, 1'b0);
            OP_READ_CAPTURE: issue_read(r.addr, '0, '0, 1'b1, 1'b0);
            OP_READ_SAME:    issue_read(r.addr, '0, '1, 1'b0, 1'b1);
            // Give the change time to pass the stages
            OP_POWER:
            begin
                fiu_pwr_state = r.data[1:0];
                settle(4);
            end
            OP_ERROR:
            begin
                fiu_error = 1'b1;
                settle(4);
            end
            OP_WAIT_DONE:    wait_done(r.test);
            OP_IDLE:         settle(int'(r.data[7:0]));
            default:         ;
        endcase
    endtask

    // Let responses drain, then mark the test boundary
    task automatic finish_test(input int id);
        int waited;
        waited = 0;
        @(negedge clk);
        clear_inputs();
        while (pending != 0 && waited < DRAIN_WAIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0)
        begin
            $display("Test %0d: %0d reads still had no response at the end", id, pending);
            drv_errors++;
        end
        test_id  = id;
        test_end = 1'b1;
        tests_run++;
    endtask

    initial
    begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        fiu_pwr_state = '0;
        clear_inputs();
        test_id       = 0;
        drv_errors    = 0;
        tests_run     = 0;
        void'($urandom(SEED));
        tid_next      = t_mmio_tid'($urandom());
        build_table();
        timeout_limit = rows.size() * 200 + 100;

        // Three cycles of reset, released on a falling edge
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < rows.size(); i++)
        begin
            apply_row(rows[i]);
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test)
                finish_test(rows[i].test);
        end
        @(negedge clk);
        clear_inputs();
        @(negedge clk);

        $display("%0d tests, %0d checks, %0d errors",
                 tests_run, check_count, error_count + drv_errors);
        if (error_count + drv_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
src/ccip_shim_pkg.sv
src/ccip_reg_stage.sv
src/afu_csr_block.sv
src/afu_counter_engine.sv
src/ccip_afu_top.sv
verification/tb_ccip_checker.sv
verification/tb_ccip_afu.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal \
    -f sources.f \
    --top-module tb_ccip_afu \
    -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_ccip_afu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
